/* Bender.yml */
package:
  name: exu

sources:
  - include_dirs:
      - .
    files:
      - exu_pkg.sv
      - exu_queue.sv
      - exu_alu.sv
      - exu_muldiv.sv
      - exu_top.sv
  - target: simulation
    include_dirs:
      - .
    files:
      - exu_checker.sv
      - exu_tb.sv

/* all.f */
+incdir+.
exu_pkg.sv
exu_queue.sv
exu_alu.sv
exu_muldiv.sv
exu_top.sv
exu_checker.sv
exu_tb.sv

/* exu_alu.sv */
`timescale 1ns/1ps
`default_nettype none

`include "exu_settings.svh"

module exu_alu (
    input  wire exu_pkg::alu_op_e  op,
    input  wire exu_pkg::src_sel_e sel,
    input  wire [`EXU_XLEN-1:0]    rs1,
    input  wire [`EXU_XLEN-1:0]    rs2,
    input  wire [`EXU_XLEN-1:0]    imm,
    input  wire [`EXU_XLEN-1:0]    pc,
    output logic [`EXU_XLEN-1:0]   a,
    output logic [`EXU_XLEN-1:0]   b,
    output logic [`EXU_XLEN-1:0]   result
);

    localparam int XLEN = `EXU_XLEN;

    logic [XLEN-1:0] sum;
    logic [XLEN-1:0] diff;
    logic [5:0]      shamt;
    logic [31:0]     sllw;

    always_comb begin
        case (sel)
            exu_pkg::SEL_RS1_IMM: begin
                a = rs1;
                b = imm;
            end
            exu_pkg::SEL_PC_IMM: begin
                a = pc;
                b = imm;
            end
            exu_pkg::SEL_PC_4: begin
                a = pc;
                b = XLEN'(4);  // link address
            end
            default: begin
                a = rs1;
                b = rs2;
            end
        endcase
    end

    assign sum   = a + b;
    assign diff  = a - b;
    assign shamt = b[5:0];
    assign sllw  = a[31:0] << b[4:0];  // word shift uses five bits

    always_comb begin
        case (op)
            exu_pkg::OP_ADD: begin
                result = sum;
            end
            exu_pkg::OP_SUB: begin
                result = diff;
            end
            exu_pkg::OP_SLL: begin
                result = a << shamt;
            end
            exu_pkg::OP_SRL: begin
                result = a >> shamt;
            end
            exu_pkg::OP_SRA: begin
                result = $signed(a) >>> shamt;
            end
            exu_pkg::OP_AND: begin
                result = a & b;
            end
            exu_pkg::OP_OR: begin
                result = a | b;
            end
            exu_pkg::OP_XOR: begin
                result = a ^ b;
            end
            exu_pkg::OP_SLT: begin
                result = XLEN'($signed(a) < $signed(b));
            end
            exu_pkg::OP_SLTU: begin
                result = XLEN'(a < b);
            end
            exu_pkg::OP_ADDW: begin
                result = {{(XLEN-32){sum[31]}}, sum[31:0]};
            end
            exu_pkg::OP_SUBW: begin
                result = {{(XLEN-32){diff[31]}}, diff[31:0]};
            end
            exu_pkg::OP_SLLW: begin
                result = {{(XLEN-32){sllw[31]}}, sllw};
            end
            default: begin
                result = '0;  // iterative ops
            end
        endcase
    end

endmodule

`default_nettype wire

/* exu_checker.sv */
`timescale 1ns/1ps
`default_nettype none

`include "exu_settings.svh"

module exu_checker (
    input wire clk,
    input wire rst_n,
    input wire req_valid,
    input wire req_credit,
    input wire pop,
    input wire res_push,
    input wire res_full,
    input wire res_valid,
    input wire res_credit,
    input wire md_start,
    input wire md_busy
);

    int unsigned fail_count = 0;
    int          issue_credits;  // issue side view of its credits
    int          req_count;      // request queue fill
    int          res_count;      // result queue fill
    int          wb_count;       // writeback side view of the unit's credits

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            issue_credits <= `EXU_REQ_DEPTH;
            req_count     <= 0;
            res_count     <= 0;
            wb_count      <= `EXU_WB_CREDITS;
        end else begin
            issue_credits <= issue_credits + int'(req_credit) - int'(req_valid);
            req_count     <= req_count + int'(req_valid) - int'(pop);
            res_count     <= res_count + int'(res_push) - int'(res_valid);
            wb_count      <= wb_count + int'(res_credit) - int'(res_valid);
        end
    end

    issue_needs_credit: assert property (@(posedge clk) disable iff (!rst_n)
        req_valid |-> issue_credits > 0)
    else begin
        fail_count++;
        $error("req_valid asserted with no issue credit left");
    end

    result_needs_credit: assert property (@(posedge clk) disable iff (!rst_n)
        res_valid |-> wb_count > 0)
    else begin
        fail_count++;
        $error("res_valid asserted with no writeback credit");
    end

    req_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
        req_valid |-> (req_count < `EXU_REQ_DEPTH || pop))
    else begin
        fail_count++;
        $error("push into a full request queue");
    end

    req_no_underflow: assert property (@(posedge clk) disable iff (!rst_n)
        pop |-> req_count > 0)
    else begin
        fail_count++;
        $error("pop from an empty request queue");
    end

    res_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
        !(res_push && res_full && !res_valid))
    else begin
        fail_count++;
        $error("push into a full result queue");
    end

    res_no_underflow: assert property (@(posedge clk) disable iff (!rst_n)
        res_valid |-> res_count > 0)
    else begin
        fail_count++;
        $error("pop from an empty result queue");
    end

    // muldiv goes busy only the cycle after a start
    busy_from_start: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(md_busy) |-> $past(md_start))
    else begin
        fail_count++;
        $error("muldiv busy rose without a start");
    end

endmodule

`default_nettype wire

/* exu_muldiv.sv */
`timescale 1ns/1ps
`default_nettype none

`include "exu_settings.svh"

module exu_muldiv (
    input  wire                   clk,
    input  wire                   rst_n,
    input  wire                   start,
    input  wire exu_pkg::alu_op_e op,
    input  wire [`EXU_XLEN-1:0]   a,
    input  wire [`EXU_XLEN-1:0]   b,
    output logic                  busy,
    output logic                  done,
    output logic [`EXU_XLEN-1:0]  result
);

    localparam int XLEN = `EXU_XLEN;
    localparam int CW   = $clog2(XLEN);

    logic [XLEN-1:0]  hi;   // product high half or partial remainder
    logic [XLEN-1:0]  lo;   // multiplier bits then quotient
    logic [XLEN-1:0]  opd;  // multiplicand or divisor magnitude
    logic             neg;
    logic             mul_q;
    exu_pkg::alu_op_e op_q;
    logic [CW-1:0]    cnt;

    logic             is_mul;
    logic             is_signed;
    logic             is_rem;
    logic             a_neg;
    logic             b_neg;
    logic             div_zero;
    logic             div_ovf;
    logic [XLEN-1:0]  s_hi;
    logic [XLEN-1:0]  s_lo;
    logic [XLEN-1:0]  s_opd;
    logic [XLEN:0]    add_sum;
    logic [XLEN:0]    rem_sh;
    logic [XLEN:0]    rem_diff;
    logic [XLEN-1:0]  nxt_hi;
    logic [XLEN-1:0]  nxt_lo;
    logic [XLEN-1:0]  mag;

    assign is_mul    = op inside {exu_pkg::OP_MUL, exu_pkg::OP_MULHU, exu_pkg::OP_MULW};
    assign is_signed = op inside {exu_pkg::OP_DIV, exu_pkg::OP_REM};
    assign is_rem    = op inside {exu_pkg::OP_REM, exu_pkg::OP_REMU};
    assign a_neg     = is_signed & a[XLEN-1];
    assign b_neg     = is_signed & b[XLEN-1];
    assign div_zero  = !is_mul && (b == '0);
    assign div_ovf   = is_signed && (a == {1'b1, {(XLEN-1){1'b0}}}) && (&b);

    // the start cycle already runs step one on the fresh operands
    assign s_hi  = start ? '0 : hi;
    assign s_lo  = start ? (is_mul ? b : (a_neg ? -a : a)) : lo;
    assign s_opd = start ? (is_mul ? a : (b_neg ? -b : b)) : opd;

    assign add_sum  = {1'b0, s_hi} + (s_lo[0] ? {1'b0, s_opd} : '0);
    assign rem_sh   = {s_hi, s_lo[XLEN-1]};
    assign rem_diff = rem_sh - {1'b0, s_opd};

    always_comb begin
        if (start ? is_mul : mul_q) begin
            nxt_hi = add_sum[XLEN:1];
            nxt_lo = {add_sum[0], s_lo[XLEN-1:1]};
        end else if (!rem_diff[XLEN]) begin
            nxt_hi = rem_diff[XLEN-1:0];  // trial subtract fits
            nxt_lo = {s_lo[XLEN-2:0], 1'b1};
        end else begin
            nxt_hi = rem_sh[XLEN-1:0];
            nxt_lo = {s_lo[XLEN-2:0], 1'b0};
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy <= 1'b0;
            done <= 1'b0;
            cnt  <= '0;
        end else begin
            done <= 1'b0;
            if (start) begin
                busy <= 1'b1;
                done <= div_zero | div_ovf;  // corner cases finish at once
                cnt  <= CW'(1);
            end else if (done) begin
                busy <= 1'b0;
            end else if (busy) begin
                cnt  <= cnt + 1'b1;
                done <= (cnt == CW'(XLEN - 1));
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            op_q  <= op;
            mul_q <= is_mul;
            opd   <= s_opd;
            if (div_zero) begin
                hi  <= a;
                lo  <= '1;
                neg <= 1'b0;
            end else if (div_ovf) begin
                hi  <= '0;
                lo  <= a;
                neg <= 1'b0;
            end else begin
                hi  <= nxt_hi;
                lo  <= nxt_lo;
                neg <= is_rem ? a_neg : (a_neg ^ b_neg);
            end
        end else if (busy && !done) begin
            hi <= nxt_hi;
            lo <= nxt_lo;
        end
    end

    assign mag = (op_q inside {exu_pkg::OP_REM, exu_pkg::OP_REMU}) ? hi : lo;

    always_comb begin
        case (op_q)
            exu_pkg::OP_MUL:   result = lo;
            exu_pkg::OP_MULHU: result = hi;
            exu_pkg::OP_MULW:  result = {{(XLEN-32){lo[31]}}, lo[31:0]};
            default:           result = neg ? -mag : mag;  // sign fixup
        endcase
    end

endmodule

`default_nettype wire

/* exu_pkg.sv */
`default_nettype none

`include "exu_settings.svh"

package exu_pkg;

    typedef enum logic [4:0] {
        OP_ADD   = 5'd1,
        OP_SLL   = 5'd3,
        OP_ADDW  = 5'd4,
        OP_SUB   = 5'd5,
        OP_SRA   = 5'd6,
        OP_AND   = 5'd7,
        OP_SLLW  = 5'd8,
        OP_XOR   = 5'd9,
        OP_OR    = 5'd10,
        OP_SRL   = 5'd11,
        OP_MULW  = 5'd12,
        OP_MULHU = 5'd13,
        OP_MUL   = 5'd16,
        OP_DIVU  = 5'd19,
        OP_DIV   = 5'd20,
        OP_REMU  = 5'd23,
        OP_REM   = 5'd24,
        OP_SUBW  = 5'd25,
        OP_SLT   = 5'd26,
        OP_SLTU  = 5'd27
    } alu_op_e;

    typedef enum logic [1:0] {
        SEL_RS1_RS2 = 2'd0,
        SEL_RS1_IMM = 2'd1,
        SEL_PC_IMM  = 2'd2,
        SEL_PC_4    = 2'd3
    } src_sel_e;

    typedef struct packed {
        alu_op_e               op;
        src_sel_e              sel;
        logic [`EXU_TAG_W-1:0] tag;
        logic [`EXU_XLEN-1:0]  rs1;
        logic [`EXU_XLEN-1:0]  rs2;
        logic [`EXU_XLEN-1:0]  imm;
        logic [`EXU_XLEN-1:0]  pc;
    } exu_req_t;

    typedef struct packed {
        logic [`EXU_TAG_W-1:0] tag;
        logic [`EXU_XLEN-1:0]  data;
    } exu_res_t;

    // ops handled by the iterative unit
    function automatic logic is_muldiv(alu_op_e op);
        return op inside {OP_MUL, OP_MULHU, OP_MULW, OP_DIV, OP_DIVU, OP_REM, OP_REMU};
    endfunction

endpackage

`default_nettype wire

/* exu_queue.sv */
`timescale 1ns/1ps
`default_nettype none

module exu_queue #(
    parameter type payload_t = logic,
    parameter int  DEPTH     = 4
) (
    input  wire           clk,
    input  wire           rst_n,
    input  wire           push,
    input  wire payload_t push_data,
    input  wire           pop,
    output payload_t      head,
    output logic          empty,
    output logic          full
);

    localparam int PW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    payload_t      mem [DEPTH];
    logic [PW-1:0] wr_ptr;
    logic [PW-1:0] rd_ptr;
    logic [PW:0]   count;

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count <= count + {{PW{1'b0}}, push} - {{PW{1'b0}}, pop};
        end
    end

    assign head  = mem[rd_ptr];
    assign empty = (count == '0);
    assign full  = (count == (PW+1)'(DEPTH));

endmodule

`default_nettype wire

/* exu_settings.svh */
`ifndef EXU_SETTINGS_SVH
`define EXU_SETTINGS_SVH

`define EXU_XLEN       64
`define EXU_REQ_DEPTH  4   // also the issue credits after reset
`define EXU_RES_DEPTH  4
`define EXU_WB_CREDITS 2
`define EXU_TAG_W      4

`endif

/* exu_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "exu_settings.svh"

module exu_tb;

    localparam int XLEN       = `EXU_XLEN;
    localparam int N_ALU      = 13 * 4 * 2;
    localparam int N_MD       = 7 * 25 + 7 * 3;
    localparam int N_MIX      = 16;
    localparam int N_STALL    = 12;
    localparam int N_OPS      = N_ALU + N_MD + N_MIX + N_STALL;
    localparam int MAX_CYCLES = 2 * 80 * N_OPS;
    localparam logic [XLEN-1:0] MIN_INT = {1'b1, {(XLEN-1){1'b0}}};

    logic                  clk;
    logic                  rst_n;
    logic                  req_valid;
    exu_pkg::alu_op_e      req_op;
    exu_pkg::src_sel_e     req_sel;
    logic [`EXU_TAG_W-1:0] req_tag;
    logic [XLEN-1:0]       req_rs1;
    logic [XLEN-1:0]       req_rs2;
    logic [XLEN-1:0]       req_imm;
    logic [XLEN-1:0]       req_pc;
    logic                  req_credit;
    logic                  res_valid;
    logic [`EXU_TAG_W-1:0] res_tag;
    logic [XLEN-1:0]       res_data;
    logic                  res_credit;

    int                    seed = 29;
    int                    credits = `EXU_REQ_DEPTH;
    int                    wb_owed = 0;  // credits the writeback side still has to return
    int                    issued = 0;
    int                    received = 0;
    int                    errors = 0;
    int                    other_errors = 0;
    int                    cycles;
    logic                  withhold = 1'b0;
    logic [31:0]           coin = '0;
    logic [`EXU_TAG_W-1:0] next_tag = '0;
    logic [`EXU_TAG_W-1:0] exp_tag[$];
    logic [XLEN-1:0]       exp_data[$];
    logic [XLEN-1:0]       corner[5] = '{MIN_INT, '1, ~MIN_INT, '0, 64'd1};

    exu_pkg::alu_op_e alu_ops[13] = '{exu_pkg::OP_ADD, exu_pkg::OP_SUB, exu_pkg::OP_SLL,
        exu_pkg::OP_SRL, exu_pkg::OP_SRA, exu_pkg::OP_AND, exu_pkg::OP_OR, exu_pkg::OP_XOR,
        exu_pkg::OP_SLT, exu_pkg::OP_SLTU, exu_pkg::OP_ADDW, exu_pkg::OP_SUBW, exu_pkg::OP_SLLW};
    exu_pkg::alu_op_e md_ops[7] = '{exu_pkg::OP_MUL, exu_pkg::OP_MULHU, exu_pkg::OP_MULW,
        exu_pkg::OP_DIV, exu_pkg::OP_DIVU, exu_pkg::OP_REM, exu_pkg::OP_REMU};

    exu_top DUT (
        .clk(clk), .rst_n(rst_n), .req_valid(req_valid), .req_op(req_op), .req_sel(req_sel),
        .req_tag(req_tag), .req_rs1(req_rs1), .req_rs2(req_rs2), .req_imm(req_imm),
        .req_pc(req_pc), .req_credit(req_credit), .res_valid(res_valid), .res_tag(res_tag),
        .res_data(res_data), .res_credit(res_credit)
    );

    bind exu_top exu_checker chk (
        .clk(clk), .rst_n(rst_n), .req_valid(req_valid), .req_credit(req_credit), .pop(pop),
        .res_push(res_push), .res_full(res_full), .res_valid(res_valid),
        .res_credit(res_credit), .md_start(md_start), .md_busy(md_busy)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [XLEN-1:0] rand64();
        return {$random(seed), $random(seed)};
    endfunction

    // expected result straight from the RISC-V rules
    function automatic logic [XLEN-1:0] expect_result(
        input exu_pkg::alu_op_e  op,
        input exu_pkg::src_sel_e sel,
        input logic [XLEN-1:0]   rs1,
        input logic [XLEN-1:0]   rs2,
        input logic [XLEN-1:0]   imm,
        input logic [XLEN-1:0]   pc
    );
        logic [XLEN-1:0]   a;
        logic [XLEN-1:0]   b;
        logic [XLEN-1:0]   w;
        logic [2*XLEN-1:0] prod;
        a = (sel == exu_pkg::SEL_PC_IMM || sel == exu_pkg::SEL_PC_4) ? pc : rs1;
        b = (sel == exu_pkg::SEL_RS1_RS2) ? rs2 : (sel == exu_pkg::SEL_PC_4) ? 64'd4 : imm;
        prod = {{XLEN{1'b0}}, a} * {{XLEN{1'b0}}, b};
        case (op)
            exu_pkg::OP_ADD:   return a + b;
            exu_pkg::OP_SUB:   return a - b;
            exu_pkg::OP_SLL:   return a << b[5:0];
            exu_pkg::OP_SRL:   return a >> b[5:0];
            exu_pkg::OP_SRA:   return $signed(a) >>> b[5:0];
            exu_pkg::OP_AND:   return a & b;
            exu_pkg::OP_OR:    return a | b;
            exu_pkg::OP_XOR:   return a ^ b;
            exu_pkg::OP_SLT:   return ($signed(a) < $signed(b)) ? 1 : 0;
            exu_pkg::OP_SLTU:  return (a < b) ? 1 : 0;
            exu_pkg::OP_MUL:   return prod[XLEN-1:0];
            exu_pkg::OP_MULHU: return prod[2*XLEN-1:XLEN];
            exu_pkg::OP_MULW:  return {{32{prod[31]}}, prod[31:0]};
            exu_pkg::OP_DIVU:  return (b == 0) ? '1 : a / b;
            exu_pkg::OP_REMU:  return (b == 0) ? a : a % b;
            default: begin
                w = (op == exu_pkg::OP_SUBW) ? a - b
                  : (op == exu_pkg::OP_SLLW) ? a << b[4:0] : a + b;
                if (op inside {exu_pkg::OP_ADDW, exu_pkg::OP_SUBW, exu_pkg::OP_SLLW}) begin
                    return {{32{w[31]}}, w[31:0]};
                end
                if (b == 0) begin
                    return (op == exu_pkg::OP_DIV) ? '1 : a;  // divide by zero
                end
                if (a == MIN_INT && b == '1) begin
                    return (op == exu_pkg::OP_DIV) ? a : '0;  // signed overflow
                end
                if (op == exu_pkg::OP_DIV) begin
                    return $signed(a) / $signed(b);
                end
                return $signed(a) % $signed(b);
            end
        endcase
    endfunction

    task automatic issue(
        input exu_pkg::alu_op_e  op,
        input exu_pkg::src_sel_e sel,
        input logic [XLEN-1:0]   rs1,
        input logic [XLEN-1:0]   rs2,
        input logic [XLEN-1:0]   imm,
        input logic [XLEN-1:0]   pc
    );
        while (credits == 0) begin
            @(negedge clk);
        end
        req_valid = 1'b1;
        req_op    = op;
        req_sel   = sel;
        req_tag   = next_tag;
        req_rs1   = rs1;
        req_rs2   = rs2;
        req_imm   = imm;
        req_pc    = pc;
        exp_tag.push_back(next_tag);
        exp_data.push_back(expect_result(op, sel, rs1, rs2, imm, pc));
        next_tag = next_tag + 1'b1;
        credits--;
        issued++;
        @(negedge clk);
        req_valid = 1'b0;
    endtask

    task automatic check_result();
        assert (exp_tag.size() != 0) else begin
            $display("error %0t: result tag %0h arrived with none outstanding", $time, res_tag);
            errors++;
        end
        if (exp_tag.size() != 0) begin
            assert (res_tag == exp_tag[0] && res_data == exp_data[0]) else begin
                $display("error %0t: got tag %0h data %h, expected tag %0h data %h",
                         $time, res_tag, res_data, exp_tag[0], exp_data[0]);
                errors++;
            end
            void'(exp_tag.pop_front());
            void'(exp_data.pop_front());
        end
        received++;
        wb_owed++;
    endtask

    task automatic drain();
        while (exp_tag.size() != 0 || wb_owed != 0) begin
            @(negedge clk);
        end
    endtask

    always @(posedge clk) begin
        coin <= $random(seed);
        if (rst_n && req_credit) begin
            credits++;
        end
        if (rst_n && res_valid) begin
            check_result();
        end
    end

    // writeback side hands credits back after a random delay
    always @(negedge clk) begin
        res_credit = !withhold && wb_owed != 0 && coin[0];
        if (res_credit) begin
            wb_owed--;
        end
    end

    initial begin
        for (cycles = 0; cycles < MAX_CYCLES; cycles++) begin
            @(posedge clk);
        end
        $display("timeout: run still busy after %0d cycles", MAX_CYCLES);
        $display(">>> FAIL");
        $finish;
    end

    initial begin
        int got;
        int k;
        rst_n      = 1'b0;
        req_valid  = 1'b0;
        req_op     = exu_pkg::OP_ADD;
        req_sel    = exu_pkg::SEL_RS1_RS2;
        req_tag    = '0;
        req_rs1    = '0;
        req_rs2    = '0;
        req_imm    = '0;
        req_pc     = '0;
        res_credit = 1'b0;
        repeat (3) @(negedge clk);
        rst_n = 1'b1;

        for (int o = 0; o < 13; o++) begin
            for (int s = 0; s < 4; s++) begin
                for (int r = 0; r < 2; r++) begin
                    issue(alu_ops[o], exu_pkg::src_sel_e'(s), rand64(), rand64(), rand64(),
                          rand64());
                end
            end
        end
        drain();

        for (int o = 0; o < 7; o++) begin
            for (int i = 0; i < 5; i++) begin
                for (int j = 0; j < 5; j++) begin
                    issue(md_ops[o], exu_pkg::SEL_RS1_RS2, corner[i], corner[j], '0, '0);
                end
            end
            for (int r = 0; r < 3; r++) begin
                issue(md_ops[o], exu_pkg::SEL_RS1_RS2, rand64(),
                      rand64() >> ($random(seed) & 63), '0, '0);
            end
        end
        drain();

        for (int m = 0; m < N_MIX; m++) begin
            k = $unsigned($random(seed)) % 20;
            issue((k < 13) ? alu_ops[k] : md_ops[k-13], exu_pkg::src_sel_e'($random(seed) & 3),
                  rand64(), rand64(), rand64(), rand64());
        end
        drain();

        withhold = 1'b1;
        fork
            for (int i = 0; i < N_STALL; i++) begin
                issue(alu_ops[i % 13], exu_pkg::SEL_RS1_IMM, rand64(), rand64(), rand64(),
                      rand64());
            end
            begin
                wait (credits == 0);
                got = received;
                repeat (40) @(negedge clk);
                assert (credits == 0 && received == got) else begin
                    $display("issue side kept going while writeback credits were withheld");
                    other_errors++;
                end
                withhold = 1'b0;
            end
        join
        drain();
        repeat (10) @(negedge clk);  // room for a duplicate to show up

        assert (received == issued) else begin
            $display("%0d results came back for %0d issued operations", received, issued);
            other_errors++;
        end
        $display("closing: %0d ops, %0d value errors, %0d other errors, %0d assertion failures",
                 issued, errors, other_errors, DUT.chk.fail_count);
        if (errors == 0 && other_errors == 0 && DUT.chk.fail_count == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* exu_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "exu_settings.svh"

module exu_top (
    input  wire                    clk,
    input  wire                    rst_n,
    input  wire                    req_valid,
    input  wire exu_pkg::alu_op_e  req_op,
    input  wire exu_pkg::src_sel_e req_sel,
    input  wire [`EXU_TAG_W-1:0]   req_tag,
    input  wire [`EXU_XLEN-1:0]    req_rs1,
    input  wire [`EXU_XLEN-1:0]    req_rs2,
    input  wire [`EXU_XLEN-1:0]    req_imm,
    input  wire [`EXU_XLEN-1:0]    req_pc,
    output logic                   req_credit,
    output logic                   res_valid,
    output logic [`EXU_TAG_W-1:0]  res_tag,
    output logic [`EXU_XLEN-1:0]   res_data,
    input  wire                    res_credit
);

    localparam int CRW = $clog2(`EXU_WB_CREDITS + 1);

    exu_pkg::exu_req_t     req_in;
    exu_pkg::exu_req_t     req_head;
    logic                  req_empty;
    logic                  head_md;
    logic                  pop;
    logic                  md_start;
    logic [`EXU_XLEN-1:0]  alu_a;
    logic [`EXU_XLEN-1:0]  alu_b;
    logic [`EXU_XLEN-1:0]  alu_result;
    logic                  md_busy;
    logic                  md_done;
    logic [`EXU_XLEN-1:0]  md_result;
    logic [`EXU_TAG_W-1:0] md_tag;  // tag of the op in the muldiv unit
    exu_pkg::exu_res_t     res_in;
    exu_pkg::exu_res_t     res_head;
    logic                  res_push;
    logic                  res_empty;
    logic                  res_full;
    logic [CRW-1:0]        wb_credits;

    assign req_in = '{op:  req_op,  sel: req_sel, tag: req_tag,
                      rs1: req_rs1, rs2: req_rs2, imm: req_imm, pc: req_pc};

    exu_queue #(.payload_t(exu_pkg::exu_req_t), .DEPTH(`EXU_REQ_DEPTH)) req_q (
        .clk(clk), .rst_n(rst_n), .push(req_valid), .push_data(req_in),
        .pop(pop), .head(req_head), .empty(req_empty), .full()
    );

    // a busy muldiv unit holds back every later op to keep results in order
    assign head_md    = exu_pkg::is_muldiv(req_head.op);
    assign pop        = !req_empty && !res_full && !md_busy;
    assign md_start   = pop && head_md;
    assign req_credit = pop;

    exu_alu u_alu (
        .op(req_head.op), .sel(req_head.sel), .rs1(req_head.rs1), .rs2(req_head.rs2),
        .imm(req_head.imm), .pc(req_head.pc), .a(alu_a), .b(alu_b), .result(alu_result)
    );

    exu_muldiv u_muldiv (
        .clk(clk), .rst_n(rst_n), .start(md_start), .op(req_head.op), .a(alu_a), .b(alu_b),
        .busy(md_busy), .done(md_done), .result(md_result)
    );

    always_ff @(posedge clk) begin
        if (md_start) begin
            md_tag <= req_head.tag;
        end
    end

    assign res_push = (pop && !head_md) || md_done;

    always_comb begin
        if (md_done) begin
            res_in.tag  = md_tag;
            res_in.data = md_result;
        end else begin
            res_in.tag  = req_head.tag;
            res_in.data = alu_result;
        end
    end

    exu_queue #(.payload_t(exu_pkg::exu_res_t), .DEPTH(`EXU_RES_DEPTH)) res_q (
        .clk(clk), .rst_n(rst_n), .push(res_push), .push_data(res_in),
        .pop(res_valid), .head(res_head), .empty(res_empty), .full(res_full)
    );

    assign res_valid = !res_empty && (wb_credits != '0);
    assign res_tag   = res_head.tag;
    assign res_data  = res_head.data;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wb_credits <= CRW'(`EXU_WB_CREDITS);
        end else if (res_credit && !res_valid) begin
            if (wb_credits != CRW'(`EXU_WB_CREDITS)) begin  // saturate at grant
                wb_credits <= wb_credits + 1'b1;
            end
        end else if (!res_credit && res_valid) begin
            wb_credits <= wb_credits - 1'b1;
        end
    end

endmodule

`default_nettype wire
